//--- Bender.yml
package:
  name: decompress

sources:
  - rtl/decompress_pkg.sv
  - rtl/api_read_ctrl.sv
  - rtl/piso_multi_rate.sv
  - rtl/coeff_decompressor.sv
  - rtl/write_addr_ctrl.sv
  - rtl/mem_write_stage.sv
  - rtl/decompress_top.sv
  - target: test
    files:
      - test/decompress_props.sv
      - test/decompress_tb.sv

//--- rtl/api_read_ctrl.sv
/* API buffer read control */

`timescale 1ns/1ps

module api_read_ctrl #(
    parameter int ADDR_W = 15
) (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             zeroize_i,
    input  logic                             decompress_enable_i,
    input  decompress_pkg::decompress_mode_t mode_i,
    input  logic [2:0]                       num_poly_i,
    input  logic [ADDR_W-1:0]                src_base_addr_i,
    input  logic                             piso_hold_i,
    input  logic                             decompress_done_i,
    output logic                             api_rd_en_o,
    output logic [ADDR_W-1:0]                api_rd_addr_o,
    output logic                             piso_valid_o
);

    logic       busy_q;
    logic [8:0] rd_cnt_q;
    logic [8:0] rd_total;
    logic       read_done;

    // One polynomial is d*4 words of 64 bits
    always_comb begin
        rd_total  = 9'(num_poly_i) * 9'(decompress_pkg::coeff_bits(mode_i)) * 9'd4;
        read_done = (rd_cnt_q == rd_total);
        api_rd_en_o = busy_q & ~read_done & ~piso_hold_i;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q        <= 1'b0;
            rd_cnt_q      <= '0;
            api_rd_addr_o <= '0;
            piso_valid_o  <= 1'b0;
        end else if (zeroize_i) begin
            busy_q        <= 1'b0;
            rd_cnt_q      <= '0;
            api_rd_addr_o <= '0;
            piso_valid_o  <= 1'b0;
        end else begin
            if (decompress_enable_i) begin
                busy_q <= 1'b1;
            end else if (decompress_done_i) begin
                busy_q <= 1'b0;
            end

            if (decompress_enable_i) begin
                rd_cnt_q      <= '0;
                api_rd_addr_o <= src_base_addr_i;
            end else if (api_rd_en_o) begin
                rd_cnt_q      <= rd_cnt_q + 9'd1;
                api_rd_addr_o <= api_rd_addr_o + ADDR_W'(1);
            end

            // Word stays presented until the PISO takes it
            piso_valid_o <= api_rd_en_o | (piso_valid_o & piso_hold_i);
        end
    end

endmodule

//--- rtl/coeff_decompressor.sv
/* Coefficient slicing and decompression */

`timescale 1ns/1ps

module coeff_decompressor (
    input  decompress_pkg::decompress_mode_t      mode_i,
    input  logic [decompress_pkg::PISO_OUT_W-1:0] data_i,
    output logic [decompress_pkg::COEFF_PER_CLK-1:0][decompress_pkg::KEM_Q_W-1:0] coeffs_o
);

    localparam int Q_W    = decompress_pkg::KEM_Q_W;
    localparam int PROD_W = 2 * Q_W;

    logic [3:0] d;

    always_comb d = decompress_pkg::coeff_bits(mode_i);

    for (genvar i = 0; i < decompress_pkg::COEFF_PER_CLK; i++) begin : g_lane
        logic [Q_W-1:0]    x;
        logic [PROD_W-1:0] prod;
        logic [Q_W-1:0]    lane;

        always_comb begin
            // Lane i starts at bit i*d of the PISO word
            case (mode_i)
                decompress_pkg::DECOMPRESS1:  x = Q_W'(data_i[i*1 +: 1]);
                decompress_pkg::DECOMPRESS5:  x = Q_W'(data_i[i*5 +: 5]);
                decompress_pkg::DECOMPRESS11: x = Q_W'(data_i[i*11 +: 11]);
                default:                      x = data_i[i*12 +: 12];
            endcase

            // round(x*q / 2^d) as (x*q + 2^(d-1)) >> d
            prod = PROD_W'(x) * PROD_W'(decompress_pkg::KEM_Q)
                 + (PROD_W'(1) << (d - 4'd1));

            if (mode_i == decompress_pkg::DECOMPRESS12) begin
                lane = x;
            end else begin
                lane = Q_W'(prod >> d);
            end
        end

        assign coeffs_o[i] = lane;
    end

endmodule

//--- rtl/decompress_pkg.sv
/* Decompression shared definitions */

package decompress_pkg;

    // Coefficient bit width selector
    typedef enum logic [1:0] {
        DECOMPRESS1  = 2'd0,
        DECOMPRESS5  = 2'd1,
        DECOMPRESS11 = 2'd2,
        DECOMPRESS12 = 2'd3
    } decompress_mode_t;

    // Memory request operation
    typedef enum logic [1:0] {
        RW_IDLE  = 2'd0,
        RW_READ  = 2'd1,
        RW_WRITE = 2'd2
    } mem_op_t;

    localparam int COEFF_PER_CLK = 4;
    localparam int API_DATA_W    = 64;
    localparam int KEM_Q_W       = 12;
    localparam int MEM_LANE_W    = 24;
    localparam int KEM_Q         = 3329;
    localparam int POLY_N        = 256;
    localparam int PISO_BUF_W    = 104;

    // Widest PISO output, four 12-bit coefficients
    localparam int PISO_OUT_W    = COEFF_PER_CLK * KEM_Q_W;

    // Bits per coefficient for a mode; PISO output rate is four times this
    function automatic logic [3:0] coeff_bits(input decompress_mode_t mode);
        case (mode)
            DECOMPRESS1:  return 4'd1;
            DECOMPRESS5:  return 4'd5;
            DECOMPRESS11: return 4'd11;
            default:      return 4'd12;
        endcase
    endfunction

endpackage

//--- rtl/decompress_top.sv
/* Decompression engine top */

`timescale 1ns/1ps

module decompress_top #(
    parameter int ADDR_W = 15
) (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              zeroize_i,
    input  logic                              decompress_enable_i,
    input  decompress_pkg::decompress_mode_t  mode_i,
    input  logic [2:0]                        num_poly_i,
    input  logic [ADDR_W-1:0]                 src_base_addr_i,
    input  logic [ADDR_W-1:0]                 dest_base_addr_i,
    input  logic [decompress_pkg::API_DATA_W-1:0] api_rd_data_i,
    output logic                              api_rd_en_o,
    output logic [ADDR_W-1:0]                 api_rd_addr_o,
    output decompress_pkg::mem_op_t           mem_wr_op_o,
    output logic [ADDR_W-1:0]                 mem_wr_addr_o,
    output logic [decompress_pkg::COEFF_PER_CLK-1:0][decompress_pkg::MEM_LANE_W-1:0] mem_wr_data_o,
    output logic                              decompress_done_o
);

    logic piso_valid;
    logic piso_hold;
    logic piso_out_valid;
    logic [decompress_pkg::PISO_OUT_W-1:0] piso_data;
    logic [decompress_pkg::COEFF_PER_CLK-1:0][decompress_pkg::KEM_Q_W-1:0] lane_coeffs;
    logic [ADDR_W-1:0] wr_addr;
    logic write_last;

    api_read_ctrl #(.ADDR_W(ADDR_W)) read_ctrl_i (
        .clk                 (clk),
        .reset_n             (reset_n),
        .zeroize_i           (zeroize_i),
        .decompress_enable_i (decompress_enable_i),
        .mode_i              (mode_i),
        .num_poly_i          (num_poly_i),
        .src_base_addr_i     (src_base_addr_i),
        .piso_hold_i         (piso_hold),
        .decompress_done_i   (decompress_done_o),
        .api_rd_en_o         (api_rd_en_o),
        .api_rd_addr_o       (api_rd_addr_o),
        .piso_valid_o        (piso_valid)
    );

    piso_multi_rate piso_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .mode_i    (mode_i),
        .valid_i   (piso_valid),
        .data_i    (api_rd_data_i),
        .hold_o    (piso_hold),
        .valid_o   (piso_out_valid),
        .data_o    (piso_data)
    );

    coeff_decompressor decomp_i (
        .mode_i   (mode_i),
        .data_i   (piso_data),
        .coeffs_o (lane_coeffs)
    );

    write_addr_ctrl #(.ADDR_W(ADDR_W)) wr_ctrl_i (
        .clk                 (clk),
        .reset_n             (reset_n),
        .zeroize_i           (zeroize_i),
        .decompress_enable_i (decompress_enable_i),
        .num_poly_i          (num_poly_i),
        .dest_base_addr_i    (dest_base_addr_i),
        .wr_valid_i          (piso_out_valid),
        .wr_addr_o           (wr_addr),
        .last_o              (write_last)
    );

    mem_write_stage #(.ADDR_W(ADDR_W)) wr_stage_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize_i),
        .wr_valid_i    (piso_out_valid),
        .wr_addr_i     (wr_addr),
        .coeffs_i      (lane_coeffs),
        .last_i        (write_last),
        .mem_wr_op_o   (mem_wr_op_o),
        .mem_wr_addr_o (mem_wr_addr_o),
        .mem_wr_data_o (mem_wr_data_o),
        .done_o        (decompress_done_o)
    );

endmodule

//--- rtl/mem_write_stage.sv
/* Memory write request register */

`timescale 1ns/1ps

module mem_write_stage #(
    parameter int ADDR_W = 15
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              zeroize_i,
    input  logic              wr_valid_i,
    input  logic [ADDR_W-1:0] wr_addr_i,
    input  logic [decompress_pkg::COEFF_PER_CLK-1:0][decompress_pkg::KEM_Q_W-1:0] coeffs_i,
    input  logic              last_i,
    output decompress_pkg::mem_op_t mem_wr_op_o,
    output logic [ADDR_W-1:0] mem_wr_addr_o,
    output logic [decompress_pkg::COEFF_PER_CLK-1:0][decompress_pkg::MEM_LANE_W-1:0] mem_wr_data_o,
    output logic              done_o
);

    localparam int PAD_W = decompress_pkg::MEM_LANE_W - decompress_pkg::KEM_Q_W;

    logic [decompress_pkg::COEFF_PER_CLK-1:0][decompress_pkg::KEM_Q_W-1:0] coeffs_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_wr_op_o <= decompress_pkg::RW_IDLE;
            done_o      <= 1'b0;
        end else if (zeroize_i) begin
            mem_wr_op_o <= decompress_pkg::RW_IDLE;
            done_o      <= 1'b0;
        end else begin
            mem_wr_op_o <= wr_valid_i ? decompress_pkg::RW_WRITE : decompress_pkg::RW_IDLE;
            // Done rides with the final write
            done_o      <= wr_valid_i & last_i;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid_i) begin
            mem_wr_addr_o <= wr_addr_i;
            coeffs_q      <= coeffs_i;
        end
    end

    // Upper bits of each memory lane stay zero
    for (genvar i = 0; i < decompress_pkg::COEFF_PER_CLK; i++) begin : g_pad
        assign mem_wr_data_o[i] = {{PAD_W{1'b0}}, coeffs_q[i]};
    end

endmodule

//--- rtl/piso_multi_rate.sv
/* Multi-rate PISO buffer */

`timescale 1ns/1ps

module piso_multi_rate (
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic                                  zeroize_i,
    input  decompress_pkg::decompress_mode_t      mode_i,
    input  logic                                  valid_i,
    input  logic [decompress_pkg::API_DATA_W-1:0] data_i,
    output logic                                  hold_o,
    output logic                                  valid_o,
    output logic [decompress_pkg::PISO_OUT_W-1:0] data_o
);

    localparam int BUF_W = decompress_pkg::PISO_BUF_W;
    localparam int IN_W  = decompress_pkg::API_DATA_W;
    localparam int CNT_W = $clog2(BUF_W + 1);

    logic [BUF_W-1:0] shift_q;
    logic [BUF_W-1:0] shift_d;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_after_out;
    logic [CNT_W-1:0] out_rate;
    logic             in_fire;

    always_comb begin
        out_rate = CNT_W'(decompress_pkg::COEFF_PER_CLK * decompress_pkg::coeff_bits(mode_i));
        valid_o  = (count_q >= out_rate);
        count_after_out = valid_o ? (count_q - out_rate) : count_q;

        // Room for a full input word must remain after this cycle's output
        hold_o  = (CNT_W'(BUF_W) - count_after_out) < CNT_W'(IN_W);
        in_fire = valid_i & ~hold_o;

        // Bits above the count are always zero, so new data is simply OR'ed in
        shift_d = valid_o ? (shift_q >> out_rate) : shift_q;
        if (in_fire) begin
            shift_d = shift_d | (BUF_W'(data_i) << count_after_out);
        end
    end

    assign data_o = shift_q[decompress_pkg::PISO_OUT_W-1:0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            shift_q <= '0;
            count_q <= '0;
        end else if (zeroize_i) begin
            shift_q <= '0;
            count_q <= '0;
        end else begin
            shift_q <= shift_d;
            count_q <= in_fire ? (count_after_out + CNT_W'(IN_W)) : count_after_out;
        end
    end

endmodule

//--- rtl/write_addr_ctrl.sv
/* Write address and completion */

`timescale 1ns/1ps

module write_addr_ctrl #(
    parameter int ADDR_W = 15
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              zeroize_i,
    input  logic              decompress_enable_i,
    input  logic [2:0]        num_poly_i,
    input  logic [ADDR_W-1:0] dest_base_addr_i,
    input  logic              wr_valid_i,
    output logic [ADDR_W-1:0] wr_addr_o,
    output logic              last_o
);

    localparam int WR_PER_POLY = decompress_pkg::POLY_N / decompress_pkg::COEFF_PER_CLK;

    logic [8:0] wr_cnt_q;
    logic [8:0] wr_total;

    // 64 writes of four coefficients per polynomial
    always_comb begin
        wr_total = 9'(num_poly_i) * 9'(WR_PER_POLY);
        last_o   = wr_valid_i & (wr_cnt_q == (wr_total - 9'd1));
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_cnt_q  <= '0;
            wr_addr_o <= '0;
        end else if (zeroize_i) begin
            wr_cnt_q  <= '0;
            wr_addr_o <= '0;
        end else if (decompress_enable_i) begin
            wr_cnt_q  <= '0;
            wr_addr_o <= dest_base_addr_i;
        end else if (wr_valid_i) begin
            wr_cnt_q  <= wr_cnt_q + 9'd1;
            wr_addr_o <= wr_addr_o + ADDR_W'(1);
        end
    end

endmodule

//--- src.f
rtl/decompress_pkg.sv
rtl/api_read_ctrl.sv
rtl/piso_multi_rate.sv
rtl/coeff_decompressor.sv
rtl/write_addr_ctrl.sv
rtl/mem_write_stage.sv
rtl/decompress_top.sv
test/decompress_props.sv
test/decompress_tb.sv

//--- test/decompress_props.sv
/* Decompression output properties */

`timescale 1ns/1ps

module decompress_props (
    input logic                    clk,
    input logic                    reset_n,
    input logic                    zeroize_i,
    input logic                    rd_en_i,
    input decompress_pkg::mem_op_t wr_op_i,
    input logic [decompress_pkg::COEFF_PER_CLK-1:0][decompress_pkg::MEM_LANE_W-1:0] wr_data_i,
    input logic                    done_i
);

    int   failures = 0;
    logic pad_zero;

    // Upper half of every lane must be zero
    always_comb begin
        pad_zero = 1'b1;
        for (int i = 0; i < decompress_pkg::COEFF_PER_CLK; i++) begin
            if (wr_data_i[i][decompress_pkg::MEM_LANE_W-1:decompress_pkg::KEM_Q_W] != '0) begin
                pad_zero = 1'b0;
            end
        end
    end

    done_with_write: assert property (@(posedge clk) disable iff (!reset_n)
        done_i |-> wr_op_i == decompress_pkg::RW_WRITE)
        else begin
            $error("done pulse without a memory write");
            failures++;
        end

    quiet_after_zeroize: assert property (@(posedge clk) disable iff (!reset_n)
        zeroize_i |=> (!rd_en_i && wr_op_i != decompress_pkg::RW_WRITE))
        else begin
            $error("read or write in the cycle after zeroize");
            failures++;
        end

    padding_zero: assert property (@(posedge clk) disable iff (!reset_n) pad_zero)
        else begin
            $error("nonzero padding bits in a memory lane");
            failures++;
        end

endmodule

bind decompress_top decompress_props props_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize_i (zeroize_i),
    .rd_en_i   (api_rd_en_o),
    .wr_op_i   (mem_wr_op_o),
    .wr_data_i (mem_wr_data_o),
    .done_i    (decompress_done_o)
);

//--- test/decompress_tb.sv
/* Decompression engine testbench */

`timescale 1ns/1ps

module decompress_tb;

    localparam int ADDR_W    = 15;
    localparam int MEM_WORDS = 512;
    localparam int LANES     = decompress_pkg::COEFF_PER_CLK;
    localparam int Q_W       = decompress_pkg::KEM_Q_W;
    localparam int LANE_W    = decompress_pkg::MEM_LANE_W;
    // API reads and memory writes summed over every command issued below
    localparam int READ_WORDS     = 432;
    localparam int WRITE_WORDS    = 14 * 64;
    localparam int TIMEOUT_CYCLES = 4 * READ_WORDS + WRITE_WORDS + 500;

    logic                                  clk;
    logic                                  reset_n;
    logic                                  zeroize_i;
    logic                                  decompress_enable_i;
    decompress_pkg::decompress_mode_t      mode_i;
    logic [2:0]                            num_poly_i;
    logic [ADDR_W-1:0]                     src_base_addr_i;
    logic [ADDR_W-1:0]                     dest_base_addr_i;
    logic [decompress_pkg::API_DATA_W-1:0] api_rd_data_i;
    logic                                  api_rd_en_o;
    logic [ADDR_W-1:0]                     api_rd_addr_o;
    decompress_pkg::mem_op_t               mem_wr_op_o;
    logic [ADDR_W-1:0]                     mem_wr_addr_o;
    logic [LANES-1:0][LANE_W-1:0]          mem_wr_data_o;
    logic                                  decompress_done_o;

    logic [decompress_pkg::API_DATA_W-1:0] api_mem [MEM_WORDS];
    logic [ADDR_W-1:0]            rd_addr_q [$];
    logic [ADDR_W-1:0]            wr_addr_q [$];
    logic [LANES-1:0][LANE_W-1:0] wr_data_q [$];
    int done_cnt;
    int done_at;
    int mismatch_cnt;
    int other_cnt;
    int cycle_cnt;

    decompress_top #(.ADDR_W(ADDR_W)) dut_i (
        .clk                 (clk),
        .reset_n             (reset_n),
        .zeroize_i           (zeroize_i),
        .decompress_enable_i (decompress_enable_i),
        .mode_i              (mode_i),
        .num_poly_i          (num_poly_i),
        .src_base_addr_i     (src_base_addr_i),
        .dest_base_addr_i    (dest_base_addr_i),
        .api_rd_data_i       (api_rd_data_i),
        .api_rd_en_o         (api_rd_en_o),
        .api_rd_addr_o       (api_rd_addr_o),
        .mem_wr_op_o         (mem_wr_op_o),
        .mem_wr_addr_o       (mem_wr_addr_o),
        .mem_wr_data_o       (mem_wr_data_o),
        .decompress_done_o   (decompress_done_o)
    );

    always #50 clk = ~clk;

    // API buffer answers one cycle after each read and all traffic is captured
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (api_rd_en_o) begin
            rd_addr_q.push_back(api_rd_addr_o);
            api_rd_data_i <= api_mem[api_rd_addr_o];
            if (api_rd_addr_o >= MEM_WORDS) begin
                $display("read at address %0d lies outside the API buffer", api_rd_addr_o);
                other_cnt++;
            end
        end
        if (mem_wr_op_o == decompress_pkg::RW_WRITE) begin
            wr_addr_q.push_back(mem_wr_addr_o);
            wr_data_q.push_back(mem_wr_data_o);
        end
        if (decompress_done_o) begin
            done_cnt++;
            done_at = wr_addr_q.size() - 1;
        end
    end

    always @(posedge clk) begin
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'hB4BC_D35C;
        end
        return state >> 1;
    endfunction

    task automatic fill_api_mem();
        logic [31:0] lfsr;
        lfsr = 32'h38298dc2;
        for (int a = 0; a < MEM_WORDS; a++) begin
            for (int b = 0; b < decompress_pkg::API_DATA_W; b++) begin
                api_mem[a][b] = lfsr[0];
                lfsr = lfsr_next(lfsr);
            end
        end
    endtask

    function automatic int mode_width(decompress_pkg::decompress_mode_t mode);
        case (mode)
            decompress_pkg::DECOMPRESS1:  return 1;
            decompress_pkg::DECOMPRESS5:  return 5;
            decompress_pkg::DECOMPRESS11: return 11;
            default:                      return 12;
        endcase
    endfunction

    // Expected coefficient k of the LSB-first stream that starts at word src
    function automatic logic [Q_W-1:0] expected_coeff(int src, int d, int k);
        int          pos;
        int          num;
        int          quo;
        int          rem;
        logic [11:0] x;
        x = '0;
        for (int b = 0; b < d; b++) begin
            pos = k * d + b;
            x[b] = api_mem[src + pos / 64][pos % 64];
        end
        if (d == 12) begin
            return x;
        end
        // Nearest integer to x*q/2^d with halves rounded up
        num = int'(x) * 3329;
        quo = num / (2 ** d);
        rem = num % (2 ** d);
        if (2 * rem >= 2 ** d) begin
            quo++;
        end
        return Q_W'(quo);
    endfunction

    task automatic check_coeff(string name, logic [Q_W-1:0] exp, logic [Q_W-1:0] act);
        if (act !== exp) begin
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_addr(string name, logic [ADDR_W-1:0] exp, logic [ADDR_W-1:0] act);
        if (act !== exp) begin
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_op(string name, decompress_pkg::mem_op_t exp,
                            decompress_pkg::mem_op_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic start_command(decompress_pkg::decompress_mode_t mode, int np,
                                 int src, int dst);
        rd_addr_q.delete();
        wr_addr_q.delete();
        wr_data_q.delete();
        done_cnt = 0;
        done_at  = -1;
        @(posedge clk);
        mode_i              <= mode;
        num_poly_i          <= 3'(np);
        src_base_addr_i     <= ADDR_W'(src);
        dest_base_addr_i    <= ADDR_W'(dst);
        decompress_enable_i <= 1'b1;
        @(posedge clk);
        decompress_enable_i <= 1'b0;
    endtask

    // Reads, writes, data and the done pulse of one finished command
    task automatic check_command(string name, decompress_pkg::decompress_mode_t mode,
                                 int np, int src, int dst);
        int d;
        int n_wr;
        d    = mode_width(mode);
        n_wr = np * decompress_pkg::POLY_N / LANES;
        check_count({name, " read count"}, np * d * 4, rd_addr_q.size());
        for (int r = 0; r < rd_addr_q.size(); r++) begin
            check_addr({name, " read address"}, ADDR_W'(src + r), rd_addr_q[r]);
        end
        check_count({name, " write count"}, n_wr, wr_addr_q.size());
        check_count({name, " done pulses"}, 1, done_cnt);
        if (done_at != n_wr - 1) begin
            $display("%s: done pulse did not come with the final write", name);
            other_cnt++;
        end
        for (int w = 0; w < wr_addr_q.size(); w++) begin
            check_addr({name, " write address"}, ADDR_W'(dst + w), wr_addr_q[w]);
            for (int i = 0; i < LANES; i++) begin
                check_coeff({name, " coefficient"}, expected_coeff(src, d, w * LANES + i),
                            wr_data_q[w][i][Q_W-1:0]);
                check_coeff({name, " padding"}, '0, wr_data_q[w][i][LANE_W-1:Q_W]);
            end
        end
    endtask

    task automatic run_command(string name, decompress_pkg::decompress_mode_t mode,
                               int np, int src, int dst);
        start_command(mode, np, src, dst);
        while (done_cnt == 0) begin
            @(posedge clk);
        end
        // Quiet period shows that no write trails the done pulse
        repeat (8) @(posedge clk);
        check_op({name, " idle after done"}, decompress_pkg::RW_IDLE, mem_wr_op_o);
        check_command(name, mode, np, src, dst);
    endtask

    task automatic test_one_poly_per_mode();
        run_command("mode 1", decompress_pkg::DECOMPRESS1, 1, 10, 2000);
        run_command("mode 5", decompress_pkg::DECOMPRESS5, 1, 20, 2100);
        run_command("mode 11", decompress_pkg::DECOMPRESS11, 1, 50, 2200);
        run_command("mode 12", decompress_pkg::DECOMPRESS12, 1, 100, 2300);
    endtask

    task automatic test_read_addressing();
        run_command("mode 11 three polys", decompress_pkg::DECOMPRESS11, 3, 160, 3000);
    endtask

    task automatic test_back_to_back();
        run_command("first of pair", decompress_pkg::DECOMPRESS5, 2, 300, 4000);
        run_command("second of pair", decompress_pkg::DECOMPRESS12, 1, 340, 100);
    endtask

    task automatic test_zeroize_mid_command();
        int n_rd;
        int n_wr;
        start_command(decompress_pkg::DECOMPRESS11, 2, 200, 5000);
        while (wr_addr_q.size() < 20) begin
            @(posedge clk);
        end
        zeroize_i <= 1'b1;
        @(posedge clk);
        zeroize_i <= 1'b0;
        @(posedge clk);
        n_rd = rd_addr_q.size();
        n_wr = wr_addr_q.size();
        repeat (10) @(posedge clk);
        check_count("reads after zeroize", n_rd, rd_addr_q.size());
        check_count("writes after zeroize", n_wr, wr_addr_q.size());
        check_count("done after zeroize", 0, done_cnt);
        check_op("op after zeroize", decompress_pkg::RW_IDLE, mem_wr_op_o);
        run_command("command after zeroize", decompress_pkg::DECOMPRESS1, 2, 400, 6000);
    endtask

    initial begin
        clk                 = 1'b0;
        reset_n             = 1'b0;
        zeroize_i           = 1'b0;
        decompress_enable_i = 1'b0;
        mode_i              = decompress_pkg::DECOMPRESS1;
        num_poly_i          = '0;
        src_base_addr_i     = '0;
        dest_base_addr_i    = '0;
        api_rd_data_i       = '0;
        mismatch_cnt        = 0;
        other_cnt           = 0;
        done_cnt            = 0;
        done_at             = -1;
        cycle_cnt           = 0;
        fill_api_mem();
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        repeat (2) @(posedge clk);

        test_one_poly_per_mode();
        test_read_addressing();
        test_back_to_back();
        test_zeroize_mid_command();

        other_cnt += dut_i.props_i.failures;
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
